/* hw/pe_array_defines.svh */
// sizing macros for the dual-MAC array
// operand and accumulator widths, grid size, tile FIFO depth, packing offset
`ifndef PE_ARRAY_DEFINES_SVH
`define PE_ARRAY_DEFINES_SVH

// operand and accumulator widths
`define PE_DATA_W 8
`define PE_ACC_W 22            // data width plus 14 guard bits

// processing element grid
`define PE_ROWS 4
`define PE_COLS 4

// D field sits this far above A in the packed multiplicand
`define PE_PACK_SHIFT 18

// completed tiles held before readout
`define TILE_FIFO_DEPTH 4

`endif

/* hw/pe_arith_pkg.sv */
// arithmetic types: operand, accumulator, operand strobe, element result, result tile
package pe_arith_pkg;

`include "pe_array_defines.svh"

    typedef logic signed [`PE_DATA_W-1:0] operand_t;
    typedef logic signed [`PE_ACC_W-1:0] acc_t;

    // one operand strobe across the whole grid
    typedef struct packed {
        operand_t [`PE_ROWS-1:0] a;    // row operand A, one per PE row
        operand_t [`PE_ROWS-1:0] d;    // row operand D, one per PE row
        operand_t [`PE_COLS-1:0] b;    // shared column operand
        logic                    first;    // restarts the accumulation
        logic                    last;    // closes the tile
    } op_req_t;

    // both accumulations of one element
    typedef struct packed {
        acc_t d_res;    // sum of D*B
        acc_t a_res;    // sum of A*B
    } pe_result_t;

    // indexed [pe row][pe col]
    typedef pe_result_t [`PE_ROWS-1:0][`PE_COLS-1:0] result_tile_t;

endpackage

/* hw/pe_readout_pkg.sv */
// readout types: mode, request and response
package pe_readout_pkg;

`include "pe_array_defines.svh"

    typedef enum logic {
        read_row = 1'b0,
        read_col = 1'b1
    } readout_mode_t;

    typedef struct packed {
        readout_mode_t                     mode;
        logic [$clog2(2 * `PE_ROWS)-1:0] index;    // tile row or column
        logic                              pop;    // drop the head tile after the read
    } rd_req_t;

    typedef struct packed {
        pe_arith_pkg::acc_t [2*`PE_ROWS-1:0] lanes;
        logic                                empty;    // no tile at the FIFO head
    } rd_rsp_t;

endpackage

/* hw/pe_dual_mac.sv */
// processing element with two signed MACs sharing operand B
// both products come from one packed unsigned multiply
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_dual_mac (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  logic                       first,
    input  logic                       last,
    input  pe_arith_pkg::operand_t     a,
    input  pe_arith_pkg::operand_t     d,
    input  pe_arith_pkg::operand_t     b,
    output logic                       done,
    output pe_arith_pkg::pe_result_t   result
);
    import pe_arith_pkg::*;

    localparam int MAG_W      = `PE_DATA_W;
    localparam int FIELD_W    = `PE_PACK_SHIFT;
    localparam int PACK_W     = `PE_PACK_SHIFT + `PE_DATA_W;
    localparam int PROD_W     = PACK_W + MAG_W;
    localparam int MAG_PROD_W = 2 * MAG_W - 1;    // 128*128 fits here

    // stage 1, sign and magnitude
    logic [MAG_W-1:0]  mag_a_s1;
    logic [MAG_W-1:0]  mag_d_s1;
    logic [MAG_W-1:0]  mag_b_s1;
    logic              neg_a_s1;
    logic              neg_d_s1;
    logic              valid_s1;
    logic              first_s1;
    logic              last_s1;
    // stage 2, packed product
    logic [PACK_W-1:0] packed_mag;
    logic [PROD_W-1:0] prod_s2;
    logic              neg_a_s2;
    logic              neg_d_s2;
    logic              valid_s2;
    logic              first_s2;
    logic              last_s2;
    // stage 3, sign correction and accumulation
    acc_t              field_a;
    acc_t              field_d;
    acc_t              term_a;
    acc_t              term_d;
    acc_t              acc_a;
    acc_t              acc_d;

    function automatic logic [MAG_W-1:0] magnitude(input operand_t x);
        return x[MAG_W-1] ? ~x + 1'b1 : x;    // -128 maps to 128
    endfunction

    always_ff @(posedge clk) begin
        mag_a_s1 <= magnitude(a);
        mag_d_s1 <= magnitude(d);
        mag_b_s1 <= magnitude(b);
        neg_a_s1 <= a[MAG_W-1] ^ b[MAG_W-1];
        neg_d_s1 <= d[MAG_W-1] ^ b[MAG_W-1];
        first_s1 <= first;
        last_s1  <= last;
    end

    // D magnitude above A with a zero gap, so the two products stay apart
    assign packed_mag = {mag_d_s1, {(FIELD_W - MAG_W){1'b0}}, mag_a_s1};

    always_ff @(posedge clk) begin
        prod_s2  <= packed_mag * mag_b_s1;
        neg_a_s2 <= neg_a_s1;
        neg_d_s2 <= neg_d_s1;
        first_s2 <= first_s1;
        last_s2  <= last_s1;
    end

    assign field_a = acc_t'(prod_s2[FIELD_W-1:0]);    // zero extended
    assign field_d = acc_t'(prod_s2[PROD_W-1:FIELD_W]);
    assign term_a  = neg_a_s2 ? -field_a : field_a;
    assign term_d  = neg_d_s2 ? -field_d : field_d;

    always_ff @(posedge clk) begin
        if (valid_s2) begin
            acc_a <= first_s2 ? term_a : acc_a + term_a;    // wraps mod 2^22
            acc_d <= first_s2 ? term_d : acc_d + term_d;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            done     <= 1'b0;
        end else begin
            valid_s1 <= valid;
            valid_s2 <= valid_s1;
            done     <= valid_s2 && last_s2;    // 3 cycles after the last strobe
        end
    end

    assign result = '{d_res: acc_d, a_res: acc_a};

    // the A product never reaches into the gap below the D field
    low_field_clear: assert property (@(posedge clk) disable iff (reset)
        valid_s2 |-> prod_s2[FIELD_W-1:MAG_PROD_W] == '0);

endmodule

/* hw/tile_fifo.sv */
// circular FIFO of completed result tiles
// a push into a full FIFO is dropped and sets a sticky overflow flag
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module tile_fifo (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  pe_arith_pkg::result_tile_t tile,
    output pe_arith_pkg::result_tile_t head,
    output logic                       empty,
    output logic                       overflow
);
    import pe_arith_pkg::*;

    localparam int DEPTH = `TILE_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    result_tile_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;    // no room, tile is lost
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= tile;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
            if (push && full) overflow <= 1'b1;    // sticky until reset
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH));

endmodule

/* hw/tile_readout.sv */
// row or column readout of the FIFO head tile, one-cycle registered response
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module tile_readout (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  pe_readout_pkg::rd_req_t    req,
    input  pe_arith_pkg::result_tile_t head,
    input  logic                       empty,
    output logic                       pop,
    output logic                       rsp_valid,
    output pe_readout_pkg::rd_rsp_t    rsp
);
    import pe_arith_pkg::*;
    import pe_readout_pkg::*;

    localparam int LANES     = 2 * `PE_ROWS;
    localparam int ROW_SEL_W = (`PE_ROWS > 1) ? $clog2(`PE_ROWS) : 1;
    localparam int COL_SEL_W = (`PE_COLS > 1) ? $clog2(`PE_COLS) : 1;

    logic [ROW_SEL_W-1:0] pe_row;
    logic [COL_SEL_W-1:0] pe_col;
    acc_t [LANES-1:0]     lanes;

    // even tile rows carry A results, odd rows D results
    function automatic acc_t pick(input pe_result_t p, input logic d_half);
        return d_half ? p.d_res : p.a_res;
    endfunction

    assign pe_row = req.index[ROW_SEL_W:1];    // tile row pair
    assign pe_col = req.index[COL_SEL_W-1:0];
    assign pop    = req_valid && req.pop && !empty;

    always_comb begin
        lanes = '0;    // unused lanes and empty reads stay zero
        if (!empty) begin
            if (req.mode == read_row) begin
                for (int c = 0; c < `PE_COLS; c++) begin
                    lanes[c] = pick(head[pe_row][c], req.index[0]);
                end
            end else begin
                for (int l = 0; l < LANES; l++) begin
                    lanes[l] = pick(head[l / 2][pe_col], (l % 2) == 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp.lanes <= lanes;
            rsp.empty <= empty;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    col_index_in_range: assert property (@(posedge clk) disable iff (reset)
        req_valid && req.mode == read_col |-> req.index < `PE_COLS);

endmodule

/* hw/pe_array.sv */
// top level: grid of dual-MAC elements feeding the tile FIFO and readout port
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_array (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    op_valid,
    input  pe_arith_pkg::op_req_t   op_req,
    input  logic                    rd_valid,
    input  pe_readout_pkg::rd_req_t rd_req,
    output logic                    rsp_valid,
    output pe_readout_pkg::rd_rsp_t rsp,
    output logic                    fifo_overflow
);
    import pe_arith_pkg::*;

    result_tile_t                      tile;
    result_tile_t                      head;
    logic [`PE_ROWS-1:0][`PE_COLS-1:0] done_grid;
    logic                              tile_valid;
    logic                              fifo_empty;
    logic                              fifo_pop;

    // A and D run along rows, B down columns
    for (genvar r = 0; r < `PE_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `PE_COLS; c++) begin : g_col
            pe_dual_mac u_pe (
                .clk    (clk),
                .reset  (reset),
                .valid  (op_valid),
                .first  (op_req.first),
                .last   (op_req.last),
                .a      (op_req.a[r]),
                .d      (op_req.d[r]),
                .b      (op_req.b[c]),
                .done   (done_grid[r][c]),
                .result (tile[r][c])
            );
        end
    end

    assign tile_valid = done_grid[0][0];    // elements finish together

    tile_fifo u_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (tile_valid),
        .pop      (fifo_pop),
        .tile     (tile),
        .head     (head),
        .empty    (fifo_empty),
        .overflow (fifo_overflow)
    );

    tile_readout u_readout (
        .clk       (clk),
        .reset     (reset),
        .req_valid (rd_valid),
        .req       (rd_req),
        .head      (head),
        .empty     (fifo_empty),
        .pop       (fifo_pop),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* dv/pe_array_checker.sv */
// monitor for the dual-MAC array
// predicts result tiles from the operand strobes and compares readout responses
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_array_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    op_valid,
    input pe_arith_pkg::op_req_t   op_req,
    input logic                    rd_valid,
    input pe_readout_pkg::rd_req_t rd_req,
    input logic                    rsp_valid,
    input pe_readout_pkg::rd_rsp_t rsp,
    input logic                    fifo_overflow
);
    import pe_arith_pkg::*;
    import pe_readout_pkg::*;

    localparam int DEPTH = `TILE_FIFO_DEPTH;
    localparam int LANES = 2 * `PE_ROWS;

    op_req_t      group[$];    // strobes of the open accumulation
    result_tile_t tiles[$];    // predicted FIFO contents, head first
    rd_rsp_t      pending[$];    // responses owed by the DUT
    int           check_count = 0;
    int           error_count = 0;

    // sum of A*B and D*B over the group, modulo 2^22
    function automatic result_tile_t tile_reference(input op_req_t strobes[$]);
        result_tile_t t;
        int           prod_a;
        int           prod_d;
        t = '0;
        for (int k = 0; k < strobes.size(); k++) begin
            for (int r = 0; r < `PE_ROWS; r++) begin
                for (int c = 0; c < `PE_COLS; c++) begin
                    prod_a = int'(strobes[k].a[r]) * int'(strobes[k].b[c]);
                    prod_d = int'(strobes[k].d[r]) * int'(strobes[k].b[c]);
                    t[r][c].a_res = t[r][c].a_res + acc_t'(prod_a);
                    t[r][c].d_res = t[r][c].d_res + acc_t'(prod_d);
                end
            end
        end
        return t;
    endfunction

    // tile row 2r is the A results of PE row r, row 2r+1 the D results
    function automatic rd_rsp_t predict_response(input rd_req_t q);
        rd_rsp_t      e;
        result_tile_t h;
        e = '0;
        if (tiles.size() == 0) begin
            e.empty = 1'b1;    // lanes stay zero
        end else begin
            h = tiles[0];
            if (q.mode == read_row) begin
                for (int c = 0; c < `PE_COLS; c++) begin
                    e.lanes[c] = q.index[0] ? h[q.index >> 1][c].d_res : h[q.index >> 1][c].a_res;
                end
            end else begin
                for (int l = 0; l < LANES; l++) begin
                    e.lanes[l] = (l % 2 == 1) ? h[l / 2][q.index].d_res : h[l / 2][q.index].a_res;
                end
            end
        end
        return e;
    endfunction

    task automatic compare_response(input rd_rsp_t exp);
        check_count++;
        if (rsp.empty !== exp.empty) begin
            error_count++;
            $display("ERR %0t: empty flag is %b, expected %b", $time, rsp.empty, exp.empty);
        end
        for (int l = 0; l < LANES; l++) begin
            if (rsp.lanes[l] !== exp.lanes[l]) begin
                error_count++;
                $display("ERR %0t: lane %0d is %0d, expected %0d", $time, l,
                         rsp.lanes[l], exp.lanes[l]);
            end
        end
    endtask

    task automatic check_overflow(input logic expected);
        check_count++;
        if (fifo_overflow !== expected) begin
            error_count++;
            $display("ERR %0t: fifo_overflow is %b, expected %b", $time, fifo_overflow, expected);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            group.delete();
            tiles.delete();
            pending.delete();
        end else begin
            // outputs here still hold the response to the previous edge's request
            if (rsp_valid) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("readout response at %0t arrived without a request", $time);
                end else begin
                    compare_response(pending.pop_front());
                end
            end else if (pending.size() != 0) begin
                error_count++;
                $display("readout response missing one cycle after its request at %0t", $time);
                void'(pending.pop_front());
            end
            if (op_valid) begin
                if (op_req.first) group.delete();
                group.push_back(op_req);
                if (op_req.last) begin
                    if (tiles.size() < DEPTH) tiles.push_back(tile_reference(group));    // else lost
                    group.delete();
                end
            end
            if (rd_valid) begin
                pending.push_back(predict_response(rd_req));
                if (rd_req.pop && tiles.size() != 0) void'(tiles.pop_front());
            end
        end
    end

endmodule

/* dv/pe_array_tb.sv */
// testbench for the dual-MAC array
// clock, reset, operand and readout stimulus, test sequence and final verdict
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_array_tb;
    import pe_arith_pkg::*;
    import pe_readout_pkg::*;

    logic    clk;
    logic    reset;
    logic    op_valid;
    op_req_t op_req;
    logic    rd_valid;
    rd_req_t rd_req;
    logic    rsp_valid;
    rd_rsp_t rsp;
    logic    fifo_overflow;
    int      timeouts = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      err_mark;
    int      timeout_mark;
    int      check_mark;

    pe_array u_dut (
        .clk           (clk),
        .reset         (reset),
        .op_valid      (op_valid),
        .op_req        (op_req),
        .rd_valid      (rd_valid),
        .rd_req        (rd_req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .fifo_overflow (fifo_overflow)
    );

    pe_array_checker u_chk (
        .clk           (clk),
        .reset         (reset),
        .op_valid      (op_valid),
        .op_req        (op_req),
        .rd_valid      (rd_valid),
        .rd_req        (rd_req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .fifo_overflow (fifo_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic operand_t random_operand();
        return ($urandom_range(7) == 0) ? operand_t'(-128) : operand_t'($urandom_range(255));
    endfunction

    function automatic operand_t extreme_operand();
        case ($urandom_range(3))
            0: return operand_t'(-128);
            1: return operand_t'(127);
            2: return operand_t'(-127);
            default: return operand_t'(-1);
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;    // inputs change away from the edge
    endtask

    task automatic send_tile(input int strobes, input bit extreme);
        op_req_t r;
        for (int k = 0; k < strobes; k++) begin
            for (int i = 0; i < `PE_ROWS; i++) begin
                r.a[i] = extreme ? extreme_operand() : random_operand();
                r.d[i] = extreme ? extreme_operand() : random_operand();
            end
            for (int j = 0; j < `PE_COLS; j++) begin
                r.b[j] = extreme ? extreme_operand() : random_operand();
            end
            r.first = (k == 0);
            r.last  = (k == strobes - 1);
            step();
            op_valid = 1'b1;
            op_req   = r;
        end
        step();
        op_valid = 1'b0;
    endtask

    // next read request lands exactly 4 cycles after the last strobe
    task automatic settle();
        repeat (2) @(posedge clk);
    endtask

    task automatic read_tile(input readout_mode_t mode, input logic [2:0] index, input logic pop);
        int waited;
        step();
        rd_valid     = 1'b1;
        rd_req.mode  = mode;
        rd_req.index = index;
        rd_req.pop   = pop;
        step();
        rd_valid = 1'b0;
        waited   = 0;
        while (!rsp_valid && waited < 8) begin
            step();
            waited++;
        end
        if (!rsp_valid) begin
            $display("timeout: no readout response to %s read of index %0d", mode.name(), index);
            timeouts++;
        end
    endtask

    task automatic begin_test();
        err_mark     = u_chk.error_count;
        timeout_mark = timeouts;
        check_mark   = u_chk.check_count;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = u_chk.error_count - err_mark + timeouts - timeout_mark;
        if (errs == 0) begin
            tests_passed++;
            $display("test %0d %s: pass, %0d checks", num, name, u_chk.check_count - check_mark);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, errs);
        end
    endtask

    initial begin
        void'($urandom(32'hd276));
        reset    = 1'b1;
        op_valid = 1'b0;
        op_req   = '0;
        rd_valid = 1'b0;
        rd_req   = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test();
        send_tile(1, 1'b0);
        settle();
        for (int i = 0; i < 2 * `PE_ROWS; i++) read_tile(read_row, 3'(i), 1'b0);
        read_tile(read_row, 3'd0, 1'b1);
        u_chk.check_overflow(1'b0);
        end_test(1, "single strobe tile");

        begin_test();
        send_tile(20, 1'b1);
        settle();
        for (int c = 0; c < `PE_COLS; c++) read_tile(read_col, 3'(c), c == `PE_COLS - 1);
        end_test(2, "multi strobe accumulation");

        begin_test();
        for (int t = 0; t < 3; t++) send_tile(2, 1'b0);
        settle();
        for (int t = 0; t < 3; t++) begin
            read_tile(read_col, 3'(t), 1'b0);
            read_tile(read_row, 3'(2 * t + 1), 1'b1);
        end
        read_tile(read_row, 3'd0, 1'b0);    // FIFO drained
        end_test(3, "queued tiles in order");

        begin_test();
        for (int t = 0; t < 5; t++) send_tile(1, 1'b0);
        settle();
        for (int t = 0; t < 4; t++) read_tile(read_col, 3'(t), 1'b1);
        read_tile(read_col, 3'd0, 1'b0);
        u_chk.check_overflow(1'b1);    // sticky since the fifth push
        end_test(4, "fifo overflow");

        begin_test();
        send_tile(3, 1'b0);
        settle();
        for (int i = 0; i < 2 * `PE_ROWS; i++) read_tile(read_row, 3'(i), 1'b0);
        read_tile(read_row, 3'd0, 1'b0);    // head unchanged by the reads above
        read_tile(read_row, 3'd5, 1'b1);
        read_tile(read_col, 3'd2, 1'b0);
        end_test(5, "row readout lanes and head");

        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors, %0d timeouts",
                 tests_passed, tests_failed, u_chk.check_count, u_chk.error_count, timeouts);
        if (tests_failed == 0 && u_chk.error_count == 0 && u_chk.check_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* pe_array.f */
+incdir+hw
hw/pe_arith_pkg.sv
hw/pe_readout_pkg.sv
hw/pe_dual_mac.sv
hw/tile_fifo.sv
hw/tile_readout.sv
hw/pe_array.sv
dv/pe_array_checker.sv
dv/pe_array_tb.sv

/* Bender.yml */
package:
  name: pe_array

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pe_arith_pkg.sv
      - hw/pe_readout_pkg.sv
      - hw/pe_dual_mac.sv
      - hw/tile_fifo.sv
      - hw/tile_readout.sv
      - hw/pe_array.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/pe_array_checker.sv
      - dv/pe_array_tb.sv
